// ==== mips_pkg.sv ====
package mips_pkg;

    localparam int WORD_W = 32;
    localparam int REG_AW = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Fetch address after reset
    localparam word_t RESET_PC = 32'h0040_0000;

    // jal link destination
    localparam reg_addr_t LINK_REG = 5'd31;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASS
    } alu_op_e;

endpackage

// ==== pipe_if.sv ====
// Decode to execute bundle, presented every cycle
interface exe_bus;
    logic                we;
    mips_pkg::reg_addr_t waddr;
    mips_pkg::alu_op_e   alu_op;
    mips_pkg::word_t     opr1;
    mips_pkg::word_t     opr2;
    logic                is_load;

    modport decode (
        output we, waddr, alu_op, opr1, opr2, is_load
    );

    modport execute (
        input we, waddr, alu_op, opr1, opr2, is_load
    );
endinterface

// Results of the three back ranks, wb group is the regfile write port
interface result_bus;
    logic                exe_we;
    mips_pkg::reg_addr_t exe_waddr;
    mips_pkg::word_t     exe_wdata;
    logic                mem_we;
    mips_pkg::reg_addr_t mem_waddr;
    mips_pkg::word_t     mem_wdata;
    logic                wb_we;
    mips_pkg::reg_addr_t wb_waddr;
    mips_pkg::word_t     wb_wdata;

    modport producer (
        output exe_we, exe_waddr, exe_wdata, mem_we, mem_waddr, mem_wdata,
        output wb_we, wb_waddr, wb_wdata
    );

    modport consumer (
        input exe_we, exe_waddr, exe_wdata, mem_we, mem_waddr, mem_wdata,
        input wb_we, wb_waddr, wb_wdata
    );
endinterface

// ==== fetch_stage.sv ====
module fetch_stage (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_branch_taken,
    input  mips_pkg::word_t i_branch_target,
    output mips_pkg::word_t o_pc,
    input  mips_pkg::word_t i_instr,
    output mips_pkg::word_t o_id_pc,
    output mips_pkg::word_t o_id_instr
);

    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t next_pc;

    assign pc_plus4 = o_pc + mips_pkg::word_t'(4);

    // Delay slot is already being fetched when the branch resolves
    assign next_pc = i_branch_taken ? i_branch_target : pc_plus4;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_pc <= mips_pkg::RESET_PC;
        end else begin
            o_pc <= next_pc;
        end
    end

    // All-zero word decodes as sll r0, a no-op
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_id_pc    <= mips_pkg::RESET_PC;
            o_id_instr <= '0;
        end else begin
            o_id_pc    <= o_pc;
            o_id_instr <= i_instr;
        end
    end

endmodule

// ==== gpr_file.sv ====
module gpr_file (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::reg_addr_t i_raddr1,
    input  mips_pkg::reg_addr_t i_raddr2,
    output mips_pkg::word_t     o_rdata1,
    output mips_pkg::word_t     o_rdata2,
    result_bus.consumer         wr
);

    mips_pkg::word_t regs [2**mips_pkg::REG_AW];

    always_ff @(posedge i_clk) begin
        if (i_rst_n && wr.wb_we) begin
            regs[wr.wb_waddr] <= wr.wb_wdata;
        end
    end

    // r0 reads zero, same-cycle write passes through
    assign o_rdata1 = (i_raddr1 == '0) ? '0 :
                      (wr.wb_we && wr.wb_waddr == i_raddr1) ? wr.wb_wdata : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 :
                      (wr.wb_we && wr.wb_waddr == i_raddr2) ? wr.wb_wdata : regs[i_raddr2];

endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  mips_pkg::word_t i_pc,
    input  mips_pkg::word_t i_instr,
    output logic            o_branch_taken,
    output mips_pkg::word_t o_branch_target,
    output mips_pkg::word_t o_dmem_addr,
    output logic            o_dmem_we,
    output mips_pkg::word_t o_dmem_wdata,
    exe_bus.decode          ex,
    result_bus.consumer     res
);

    mips_pkg::opcode_e   opcode;
    mips_pkg::funct_e    funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [4:0]          shamt;
    mips_pkg::word_t     imm_sext;
    mips_pkg::word_t     imm_zext;
    mips_pkg::word_t     pc_plus4;
    mips_pkg::word_t     rf_rdata1;
    mips_pkg::word_t     rf_rdata2;
    mips_pkg::word_t     rs_val;
    mips_pkg::word_t     rt_val;
    mips_pkg::word_t     mem_addr;

    assign opcode   = mips_pkg::opcode_e'(i_instr[31:26]);
    assign funct    = mips_pkg::funct_e'(i_instr[5:0]);
    assign rs       = i_instr[25:21];
    assign rt       = i_instr[20:16];
    assign rd       = i_instr[15:11];
    assign shamt    = i_instr[10:6];
    assign imm_sext = {{16{i_instr[15]}}, i_instr[15:0]};
    assign imm_zext = {16'h0000, i_instr[15:0]};
    assign pc_plus4 = i_pc + mips_pkg::word_t'(4);

    gpr_file u_gpr_file (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_raddr1 (rs),
        .i_raddr2 (rt),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2),
        .wr       (res)
    );

    // Youngest in-flight result wins over the register file read
    assign rs_val = (res.exe_we && res.exe_waddr == rs) ? res.exe_wdata :
                    (res.mem_we && res.mem_waddr == rs) ? res.mem_wdata : rf_rdata1;
    assign rt_val = (res.exe_we && res.exe_waddr == rt) ? res.exe_wdata :
                    (res.mem_we && res.mem_waddr == rt) ? res.mem_wdata : rf_rdata2;

    always_comb begin
        ex.we      = 1'b0;
        ex.waddr   = rd;
        ex.alu_op  = mips_pkg::ALU_PASS;
        ex.opr1    = rs_val;
        ex.opr2    = rt_val;
        ex.is_load = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                ex.we = 1'b1;
                case (funct)
                    mips_pkg::F_ADDU: ex.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUBU: ex.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  ex.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   ex.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_XOR:  ex.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::F_NOR:  ex.alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::F_SLT:  ex.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::F_SLTU: ex.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::F_SLL:  ex.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::F_SRL:  ex.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::F_SRA:  ex.alu_op = mips_pkg::ALU_SRA;
                    default:          ex.we     = 1'b0;
                endcase
                // Shifts take the amount from the first operand
                if (funct == mips_pkg::F_SLL || funct == mips_pkg::F_SRL ||
                    funct == mips_pkg::F_SRA) begin
                    ex.opr1 = {27'd0, shamt};
                end
            end
            mips_pkg::OP_ADDIU: begin
                ex.we     = 1'b1;
                ex.waddr  = rt;
                ex.alu_op = mips_pkg::ALU_ADD;
                ex.opr2   = imm_sext;
            end
            mips_pkg::OP_SLTI: begin
                ex.we     = 1'b1;
                ex.waddr  = rt;
                ex.alu_op = mips_pkg::ALU_SLT;
                ex.opr2   = imm_sext;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                ex.we    = 1'b1;
                ex.waddr = rt;
                ex.opr2  = imm_zext;
                case (opcode)
                    mips_pkg::OP_ANDI: ex.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  ex.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI: ex.alu_op = mips_pkg::ALU_XOR;
                    default:           ex.alu_op = mips_pkg::ALU_LUI;
                endcase
            end
            mips_pkg::OP_LW: begin
                ex.we      = 1'b1;
                ex.waddr   = rt;
                ex.is_load = 1'b1;
            end
            mips_pkg::OP_JAL: begin
                ex.we    = 1'b1;
                ex.waddr = mips_pkg::LINK_REG;
                ex.opr1  = i_pc + mips_pkg::word_t'(8);
            end
            default: ;
        endcase
        if (ex.waddr == '0) begin
            ex.we = 1'b0;
        end
    end

    // Branches and jumps resolve here with one delay slot
    always_comb begin
        o_branch_taken  = 1'b0;
        o_branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
        case (opcode)
            mips_pkg::OP_BEQ: o_branch_taken = (rs_val == rt_val);
            mips_pkg::OP_BNE: o_branch_taken = (rs_val != rt_val);
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                o_branch_taken  = 1'b1;
                o_branch_target = {pc_plus4[31:28], i_instr[25:0], 2'b00};
            end
            default: ;
        endcase
    end

    assign mem_addr     = rs_val + imm_sext;
    assign o_dmem_addr  = {mem_addr[31:2], 2'b00};
    assign o_dmem_we    = (opcode == mips_pkg::OP_SW);
    assign o_dmem_wdata = rt_val;

endmodule

// ==== alu.sv ====
module alu (
    input  mips_pkg::alu_op_e i_op,
    input  mips_pkg::word_t   i_opr1,
    input  mips_pkg::word_t   i_opr2,
    output mips_pkg::word_t   o_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Decode loads shamt into the first operand
    assign shamt       = i_opr1[4:0];
    assign lt_signed   = $signed(i_opr1) < $signed(i_opr2);
    assign lt_unsigned = i_opr1 < i_opr2;

    always_comb begin
        case (i_op)
            mips_pkg::ALU_ADD:  o_result = i_opr1 + i_opr2;
            mips_pkg::ALU_SUB:  o_result = i_opr1 - i_opr2;
            mips_pkg::ALU_AND:  o_result = i_opr1 & i_opr2;
            mips_pkg::ALU_OR:   o_result = i_opr1 | i_opr2;
            mips_pkg::ALU_XOR:  o_result = i_opr1 ^ i_opr2;
            mips_pkg::ALU_NOR:  o_result = ~(i_opr1 | i_opr2);
            mips_pkg::ALU_SLT: begin
                o_result = {{(mips_pkg::WORD_W-1){1'b0}}, lt_signed};
            end
            mips_pkg::ALU_SLTU: begin
                o_result = {{(mips_pkg::WORD_W-1){1'b0}}, lt_unsigned};
            end
            mips_pkg::ALU_SLL:  o_result = i_opr2 << shamt;
            mips_pkg::ALU_SRL:  o_result = i_opr2 >> shamt;
            mips_pkg::ALU_SRA:  o_result = $signed(i_opr2) >>> shamt;
            mips_pkg::ALU_LUI:  o_result = {i_opr2[15:0], 16'h0000};
            // Link value and anything unlisted pass straight through
            default:            o_result = i_opr1;
        endcase
    end

endmodule

// ==== execute_stage.sv ====
module execute_stage (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  mips_pkg::word_t i_dmem_rdata,
    exe_bus.execute         ex,
    result_bus.producer     res
);

    logic                ex_we;
    logic                ex_is_load;
    mips_pkg::reg_addr_t ex_waddr;
    mips_pkg::alu_op_e   ex_alu_op;
    mips_pkg::word_t     ex_opr1;
    mips_pkg::word_t     ex_opr2;
    mips_pkg::word_t     alu_result;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ex_we      <= 1'b0;
            ex_is_load <= 1'b0;
        end else begin
            ex_we      <= ex.we;
            ex_is_load <= ex.is_load;
        end
        ex_waddr  <= ex.waddr;
        ex_alu_op <= ex.alu_op;
        ex_opr1   <= ex.opr1;
        ex_opr2   <= ex.opr2;
    end

    alu u_alu (
        .i_op     (ex_alu_op),
        .i_opr1   (ex_opr1),
        .i_opr2   (ex_opr2),
        .o_result (alu_result)
    );

    // Load data arrives one cycle after decode put out the address
    assign res.exe_we    = ex_we;
    assign res.exe_waddr = ex_waddr;
    assign res.exe_wdata = ex_is_load ? i_dmem_rdata : alu_result;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            res.mem_we <= 1'b0;
            res.wb_we  <= 1'b0;
        end else begin
            res.mem_we <= res.exe_we;
            res.wb_we  <= res.mem_we;
        end
        res.mem_waddr <= res.exe_waddr;
        res.mem_wdata <= res.exe_wdata;
        res.wb_waddr  <= res.mem_waddr;
        res.wb_wdata  <= res.mem_wdata;
    end

endmodule

// ==== mips_core.sv ====
module mips_core (
    input  logic            i_clk,
    input  logic            i_rst_n,
    output mips_pkg::word_t o_imem_raddr,
    input  mips_pkg::word_t i_imem_rdata,
    output mips_pkg::word_t o_dmem_addr,
    output logic            o_dmem_we,
    output mips_pkg::word_t o_dmem_wdata,
    input  mips_pkg::word_t i_dmem_rdata
);

    logic            branch_taken;
    mips_pkg::word_t branch_target;
    mips_pkg::word_t id_pc;
    mips_pkg::word_t id_instr;

    exe_bus    u_exe_bus ();
    result_bus u_result_bus ();

    fetch_stage u_fetch_stage (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_pc            (o_imem_raddr),
        .i_instr         (i_imem_rdata),
        .o_id_pc         (id_pc),
        .o_id_instr      (id_instr)
    );

    decode_stage u_decode_stage (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_pc            (id_pc),
        .i_instr         (id_instr),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_wdata    (o_dmem_wdata),
        .ex              (u_exe_bus),
        .res             (u_result_bus)
    );

    execute_stage u_execute_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_dmem_rdata (i_dmem_rdata),
        .ex           (u_exe_bus),
        .res          (u_result_bus)
    );

endmodule

// ==== tb_mips_core.sv ====
module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam mips_pkg::word_t DONE_ADDR = 32'h0000_03fc;

    logic            clk = 1'b0;
    logic            rst_n;
    mips_pkg::word_t imem_raddr;
    mips_pkg::word_t imem_rdata;
    mips_pkg::word_t imem_off;
    mips_pkg::word_t dmem_addr;
    logic            dmem_we;
    mips_pkg::word_t dmem_wdata;
    mips_pkg::word_t dmem_rdata;

    mips_pkg::word_t imem [IMEM_DEPTH];
    mips_pkg::word_t dmem [DMEM_DEPTH];
    mips_pkg::word_t prog [$];
    mips_pkg::word_t exp_addr [$];
    mips_pkg::word_t exp_data [$];

    int seed = 84709;
    int cycles = 0;
    int cycle_limit = 0;
    int fail_count = 0;
    int test_errs = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    always #5 clk = ~clk;

    mips_core u_mips_core (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .o_imem_raddr (imem_raddr),
        .i_imem_rdata (imem_rdata),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata)
    );

    // Instruction memory starts at the reset PC, reads as nop elsewhere
    assign imem_off   = imem_raddr - mips_pkg::RESET_PC;
    assign imem_rdata = (imem_off < mips_pkg::word_t'(4 * IMEM_DEPTH)) ? imem[imem_off[9:2]] : '0;

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
        dmem_rdata <= dmem[dmem_addr[9:2]];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the program never reached its end", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic mips_pkg::word_t r_type(logic [5:0] funct, mips_pkg::reg_addr_t rd,
                                               mips_pkg::reg_addr_t rs, mips_pkg::reg_addr_t rt,
                                               logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic mips_pkg::word_t i_type(logic [5:0] op, mips_pkg::reg_addr_t rt,
                                               mips_pkg::reg_addr_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t j_type(logic [5:0] op, int target_idx);
        mips_pkg::word_t addr;
        addr = mips_pkg::RESET_PC + mips_pkg::word_t'(4 * target_idx);
        return {op, addr[27:2]};
    endfunction

    // Background word built from the full byte address
    function automatic mips_pkg::word_t fill_value(int idx);
        return 32'hdada_0000 | mips_pkg::word_t'(idx * 4);
    endfunction

    task automatic check_word(string name, mips_pkg::word_t got, mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_addr(string name, mips_pkg::word_t got, mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic begin_test();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        test_errs = 0;
        foreach (dmem[i]) dmem[i] = fill_value(i);
    endtask

    task automatic expect_word(mips_pkg::word_t addr, mips_pkg::word_t value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    task automatic store_expect(mips_pkg::reg_addr_t r, int slot, mips_pkg::word_t value);
        prog.push_back(i_type(mips_pkg::OP_SW, r, 5'd0, 16'(slot * 4)));
        expect_word(mips_pkg::word_t'(slot * 4), value);
    endtask

    // Store that must never execute
    task automatic skipped_store(int slot);
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd10, 5'd0, 16'(slot * 4)));
        expect_word(mips_pkg::word_t'(slot * 4), fill_value(slot));
    endtask

    task automatic emit_branch(logic [5:0] op, mips_pkg::reg_addr_t rs,
                               mips_pkg::reg_addr_t rt, int to);
        prog.push_back(i_type(op, rt, rs, 16'(to - prog.size() - 1)));
    endtask

    task automatic start_program();
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, DONE_ADDR[15:0]));
        foreach (imem[i]) imem[i] = '0;
        foreach (prog[i]) imem[i] = prog[i];
        cycle_limit = cycle_limit + prog.size() + 20 + 8;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // End marker store, then one edge so its write lands
    task automatic wait_done();
        @(negedge clk);
        while (!(dmem_we && dmem_addr == DONE_ADDR)) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic end_test(string name);
        foreach (exp_addr[i]) begin
            check_word($sformatf("dmem[%h]", exp_addr[i]), dmem[exp_addr[i][9:2]], exp_data[i]);
        end
        if (test_errs == 0) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", name, test_errs);
            tests_failed++;
        end
        fail_count = fail_count + test_errs;
    endtask

    task automatic test_reset_fetch();
        begin_test();
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5));
        prog.push_back('0);
        prog.push_back('0);
        store_expect(5'd1, 0, 32'd5);
        start_program();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_addr("o_imem_raddr", imem_raddr, mips_pkg::RESET_PC + mips_pkg::word_t'(4 * i));
            if (dmem_we) begin
                $display("o_dmem_we went high before the first store was decoded");
                test_errs++;
            end
        end
        wait_done();
        end_test("reset and fetch order");
    endtask

    task automatic test_alu(int round);
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t sx;
        mips_pkg::word_t zx;
        logic [4:0]      sh;
        begin_test();
        a  = $random(seed);
        b  = $random(seed);
        sh = b[4:0];
        zx = {16'h0000, b[15:0]};
        sx = {{16{b[15]}}, b[15:0]};
        prog.push_back(i_type(mips_pkg::OP_LUI, 5'd1, 5'd0, a[31:16]));
        prog.push_back(i_type(mips_pkg::OP_ORI, 5'd1, 5'd1, a[15:0]));
        prog.push_back(i_type(mips_pkg::OP_LUI, 5'd2, 5'd0, b[31:16]));
        prog.push_back(i_type(mips_pkg::OP_ORI, 5'd2, 5'd2, b[15:0]));
        prog.push_back(r_type(mips_pkg::F_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 0, a + b);
        prog.push_back(r_type(mips_pkg::F_SUBU, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 1, a - b);
        prog.push_back(r_type(mips_pkg::F_AND, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 2, a & b);
        prog.push_back(r_type(mips_pkg::F_OR, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 3, a | b);
        prog.push_back(r_type(mips_pkg::F_XOR, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 4, a ^ b);
        prog.push_back(r_type(mips_pkg::F_NOR, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 5, ~(a | b));
        prog.push_back(r_type(mips_pkg::F_SLT, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 6, {31'd0, $signed(a) < $signed(b)});
        prog.push_back(r_type(mips_pkg::F_SLTU, 5'd3, 5'd1, 5'd2, 5'd0));
        store_expect(5'd3, 7, {31'd0, a < b});
        prog.push_back(r_type(mips_pkg::F_SLL, 5'd3, 5'd0, 5'd1, sh));
        store_expect(5'd3, 8, a << sh);
        prog.push_back(r_type(mips_pkg::F_SRL, 5'd3, 5'd0, 5'd1, sh));
        store_expect(5'd3, 9, a >> sh);
        prog.push_back(r_type(mips_pkg::F_SRA, 5'd3, 5'd0, 5'd1, sh));
        store_expect(5'd3, 10, mips_pkg::word_t'($signed(a) >>> sh));
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd3, 5'd1, b[15:0]));
        store_expect(5'd3, 11, a + sx);
        prog.push_back(i_type(mips_pkg::OP_ANDI, 5'd3, 5'd1, b[15:0]));
        store_expect(5'd3, 12, a & zx);
        prog.push_back(i_type(mips_pkg::OP_ORI, 5'd3, 5'd1, b[15:0]));
        store_expect(5'd3, 13, a | zx);
        prog.push_back(i_type(mips_pkg::OP_XORI, 5'd3, 5'd1, b[15:0]));
        store_expect(5'd3, 14, a ^ zx);
        prog.push_back(i_type(mips_pkg::OP_SLTI, 5'd3, 5'd1, b[15:0]));
        store_expect(5'd3, 15, {31'd0, $signed(a) < $signed(sx)});
        prog.push_back(i_type(mips_pkg::OP_LUI, 5'd3, 5'd0, b[15:0]));
        store_expect(5'd3, 16, {b[15:0], 16'h0000});
        start_program();
        wait_done();
        end_test($sformatf("alu round %0d", round));
    endtask

    task automatic test_forwarding();
        mips_pkg::word_t v1;
        mips_pkg::word_t v2;
        mips_pkg::word_t v4;
        mips_pkg::word_t v5;
        begin_test();
        v1 = 32'd7;
        v2 = v1 + 32'd5;
        v4 = v2 - v1;
        v5 = v4 ^ 32'd100;
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd7));
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd2, 5'd1, 16'd5));
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd100));
        // r2 two back, r1 three back
        prog.push_back(r_type(mips_pkg::F_SUBU, 5'd4, 5'd2, 5'd1, 5'd0));
        prog.push_back(r_type(mips_pkg::F_XOR, 5'd5, 5'd4, 5'd3, 5'd0));
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd99));
        prog.push_back(r_type(mips_pkg::F_ADDU, 5'd6, 5'd0, 5'd5, 5'd0));
        store_expect(5'd6, 0, v5);
        store_expect(5'd0, 1, 32'd0);
        prog.push_back(r_type(mips_pkg::F_ADDU, 5'd7, 5'd1, 5'd2, 5'd0));
        store_expect(5'd7, 2, v1 + v2);
        start_program();
        wait_done();
        end_test("forwarding");
    endtask

    task automatic test_loads();
        mips_pkg::word_t x;
        mips_pkg::word_t y;
        begin_test();
        x = $random(seed);
        y = $random(seed);
        dmem[16] = 32'h0000_0080;
        dmem[17] = y;
        dmem[32] = x;
        prog.push_back(i_type(mips_pkg::OP_LW, 5'd1, 5'd0, 16'h0040));
        prog.push_back(i_type(mips_pkg::OP_LW, 5'd2, 5'd1, 16'h0000));
        store_expect(5'd2, 20, x);
        prog.push_back(i_type(mips_pkg::OP_LW, 5'd4, 5'd0, 16'h0040));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd2, 5'd4, 16'h0004));
        expect_word(32'h0000_0084, x);
        prog.push_back(i_type(mips_pkg::OP_LW, 5'd3, 5'd0, 16'h0044));
        prog.push_back(r_type(mips_pkg::F_ADDU, 5'd5, 5'd3, 5'd3, 5'd0));
        store_expect(5'd5, 21, y + y);
        start_program();
        wait_done();
        end_test("loads");
    endtask

    task automatic test_branches();
        begin_test();
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5));
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd5));
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd6));
        prog.push_back(i_type(mips_pkg::OP_ADDIU, 5'd10, 5'd0, 16'd1));
        emit_branch(mips_pkg::OP_BEQ, 5'd1, 5'd2, 7);
        store_expect(5'd10, 0, 32'd1);
        skipped_store(1);
        emit_branch(mips_pkg::OP_BNE, 5'd1, 5'd2, 10);
        store_expect(5'd10, 2, 32'd1);
        store_expect(5'd10, 3, 32'd1);
        emit_branch(mips_pkg::OP_BNE, 5'd1, 5'd3, 13);
        store_expect(5'd10, 4, 32'd1);
        skipped_store(5);
        emit_branch(mips_pkg::OP_BEQ, 5'd1, 5'd3, 16);
        store_expect(5'd10, 6, 32'd1);
        store_expect(5'd10, 7, 32'd1);
        prog.push_back(j_type(mips_pkg::OP_J, 19));
        store_expect(5'd10, 8, 32'd1);
        skipped_store(9);
        prog.push_back(j_type(mips_pkg::OP_JAL, 22));
        store_expect(5'd10, 10, 32'd1);
        skipped_store(11);
        // jal sits at index 19
        store_expect(5'd31, 12, mips_pkg::RESET_PC + mips_pkg::word_t'(19 * 4 + 8));
        start_program();
        wait_done();
        end_test("branches and jumps");
    endtask

    initial begin
        rst_n = 1'b0;
        dmem_rdata = '0;
        test_reset_fetch();
        test_alu(0);
        test_alu(1);
        test_forwarding();
        test_loads();
        test_branches();
        $display("Tests passed %0d failed %0d, checks failed %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== mips_core.f ====
mips_pkg.sv
pipe_if.sv
fetch_stage.sv
gpr_file.sv
decode_stage.sv
alu.sv
execute_stage.sv
mips_core.sv
tb_mips_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_mips_core
FILELIST  := mips_core.f
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
